/* hw/sync_fifo_pkg.sv */
// depth, threshold and width constants, pointer types and status structs
`default_nettype none

package sync_fifo_pkg;

   // --------------------
   // sizing
   // --------------------
   // fixed power-of-two depth
   localparam int FIFO_DEPTH = 16;
   // storage address bits
   localparam int ADDR_W = $clog2(FIFO_DEPTH);
   // one extra wrap bit on top of the address
   localparam int PTR_W = ADDR_W + 1;
   // payload word
   localparam int DATA_W = 16;

   // --------------------
   // static thresholds
   // --------------------
   // almost-full set/clear point
   localparam int AFULL_LEVEL = 12;
   // almost-empty set/clear point
   localparam int AEMPTY_LEVEL = 3;

   // --------------------
   // types
   // --------------------
   typedef logic [ADDR_W-1:0] addr_t;
   // pointer or fill count, modulo 2*depth
   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [DATA_W-1:0] data_t;

   // write side status, all registered
   typedef struct packed {
      logic full;
      logic afull;
      // one cycle after an accepted write
      logic wack;
      // write attempted while full
      logic overflow;
      ptr_t wrcnt;
   } wr_status_t;

   // read side status, all registered
   typedef struct packed {
      logic empty;
      logic aempty;
      // rd_data_o holds a fresh word
      logic dvld;
      // read attempted while empty
      logic underflow;
      ptr_t rdcnt;
   } rd_status_t;

endpackage

`default_nettype wire

/* hw/fifo_write_ctrl.sv */
// write pointer, write address, full and almost-full flags, write count, wack and overflow
`default_nettype none

module fifo_write_ctrl
   import sync_fifo_pkg::*;
(
   input  logic       pos_clk,
   input  logic       aresetn,
   input  logic       wr_en_i,
   input  ptr_t       rptr_i,
   output ptr_t       wptr_o,
   output logic       mem_we_o,
   output addr_t      mem_waddr_o,
   output wr_status_t wr_status_o
);

   // registered write pointer, wrap bit in msb
   ptr_t wptr_r;
   // pointer after this cycle's write
   ptr_t wptr_nxt;
   // fill level seen from the write side
   ptr_t wlevel;
   logic wr_accept;
   // almost-full hysteresis terms
   logic afull_set;
   logic afull_clr;
   logic afull_nxt;

   // --------------------
   // acceptance
   // --------------------
   // only the registered full flag gates a write
   assign wr_accept = wr_en_i & ~wr_status_o.full;

   // advance by one on an accepted write
   assign wptr_nxt = wptr_r + ptr_t'(wr_accept);

   // level uses the look-ahead write pointer
   // and the current read pointer, mod 32
   assign wlevel = wptr_nxt - rptr_i;

   // --------------------
   // almost-full rule
   // --------------------
   // set needs a write request at or above threshold
   assign afull_set = wr_en_i & (wlevel >= ptr_t'(AFULL_LEVEL));
   // clear at or below threshold
   assign afull_clr = (wlevel <= ptr_t'(AFULL_LEVEL));

   // set wins, then clear, else hold
   always_comb begin
      if (afull_set) begin
         afull_nxt = 1'b1;
      end else if (afull_clr) begin
         afull_nxt = 1'b0;
      end else begin
         afull_nxt = wr_status_o.afull;
      end
   end

   // --------------------
   // pointer register
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wptr_r <= '0;
      end else if (wr_accept) begin
         wptr_r <= wptr_nxt;
      end
   end

   // --------------------
   // status registers
   // --------------------
   // everything here shows one cycle after the edge
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_status_o.full     <= 1'b0;
         wr_status_o.afull    <= 1'b0;
         wr_status_o.wack     <= 1'b0;
         wr_status_o.overflow <= 1'b0;
         wr_status_o.wrcnt    <= '0;
      end else begin
         // full once all entries are taken
         wr_status_o.full     <= (wlevel >= ptr_t'(FIFO_DEPTH));
         wr_status_o.afull    <= afull_nxt;
         wr_status_o.wack     <= wr_accept;
         // rejected write, data dropped
         wr_status_o.overflow <= wr_en_i & wr_status_o.full;
         wr_status_o.wrcnt    <= wlevel;
      end
   end

   // --------------------
   // outputs
   // --------------------
   // read side compares against the registered pointer
   assign wptr_o = wptr_r;

   // storage written at the accepting edge
   assign mem_we_o = wr_accept;
   // low bits address the array, depth is a power of two
   assign mem_waddr_o = wptr_r[ADDR_W-1:0];

endmodule

`default_nettype wire

/* hw/fifo_ram.sv */
// storage array with synchronous write and registered read port
`default_nettype none

module fifo_ram
   import sync_fifo_pkg::*;
#(
   parameter type payload_t = data_t
) (
   input  logic     pos_clk,
   input  logic     aresetn,
   input  logic     we_i,
   input  addr_t    waddr_i,
   input  payload_t wdata_i,
   input  logic     re_i,
   input  addr_t    raddr_i,
   output payload_t rdata_o
);

   // one entry per address
   payload_t mem [FIFO_DEPTH];
   // output register
   payload_t rdata_r;

   // --------------------
   // write port
   // --------------------
   always_ff @(posedge pos_clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // --------------------
   // read port
   // --------------------
   // loads only on a read strobe, so the word holds between reads
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rdata_r <= '0;
      end else if (re_i) begin
         rdata_r <= mem[raddr_i];
      end
   end

   assign rdata_o = rdata_r;

endmodule

`default_nettype wire

/* hw/fifo_read_ctrl.sv */
// read pointer, read address, empty and almost-empty flags, read count, dvld and underflow
`default_nettype none

module fifo_read_ctrl
   import sync_fifo_pkg::*;
(
   input  logic       pos_clk,
   input  logic       aresetn,
   input  logic       rd_en_i,
   input  ptr_t       wptr_i,
   output ptr_t       rptr_o,
   output logic       mem_re_o,
   output addr_t      mem_raddr_o,
   output rd_status_t rd_status_o
);

   // registered read pointer, wrap bit in msb
   ptr_t rptr_r;
   // pointer after this cycle's read
   ptr_t rptr_nxt;
   // fill level seen from the read side
   ptr_t rlevel;
   logic rd_accept;
   // almost-empty hysteresis terms
   logic aempty_set;
   logic aempty_clr;
   logic aempty_nxt;

   // --------------------
   // acceptance
   // --------------------
   // only the registered empty flag gates a read
   assign rd_accept = rd_en_i & ~rd_status_o.empty;

   // advance by one on an accepted read
   assign rptr_nxt = rptr_r + ptr_t'(rd_accept);

   // current write pointer minus look-ahead read pointer
   assign rlevel = wptr_i - rptr_nxt;

   // --------------------
   // almost-empty rule
   // --------------------
   // clear needs the flag already set
   assign aempty_clr = rd_status_o.aempty & (rlevel >= ptr_t'(AEMPTY_LEVEL));
   // set needs a read request at or below threshold
   assign aempty_set = rd_en_i & (rlevel <= ptr_t'(AEMPTY_LEVEL));

   // Clear has priority over set here, the opposite of almost-full.
   always_comb begin
      if (aempty_clr) begin
         aempty_nxt = 1'b0;
      end else if (aempty_set) begin
         aempty_nxt = 1'b1;
      end else begin
         aempty_nxt = rd_status_o.aempty;
      end
   end

   // --------------------
   // pointer register
   // --------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rptr_r <= '0;
      end else if (rd_accept) begin
         rptr_r <= rptr_nxt;
      end
   end

   // --------------------
   // status registers
   // --------------------
   // empty and aempty come out of reset high
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rd_status_o.empty     <= 1'b1;
         rd_status_o.aempty    <= 1'b1;
         rd_status_o.dvld      <= 1'b0;
         rd_status_o.underflow <= 1'b0;
         rd_status_o.rdcnt     <= '0;
      end else begin
         // nothing left after this read
         rd_status_o.empty     <= (rlevel == '0);
         rd_status_o.aempty    <= aempty_nxt;
         // lines up with the registered ram output
         rd_status_o.dvld      <= rd_accept;
         // rejected read, pointer untouched
         rd_status_o.underflow <= rd_en_i & rd_status_o.empty;
         rd_status_o.rdcnt     <= rlevel;
      end
   end

   // --------------------
   // outputs
   // --------------------
   // write side compares against the registered pointer
   assign rptr_o = rptr_r;

   // ram loads its output register at the accepting edge
   assign mem_re_o = rd_accept;
   // low bits only
   assign mem_raddr_o = rptr_r[ADDR_W-1:0];

endmodule

`default_nettype wire

/* hw/sync_fifo_top.sv */
// synchronous FIFO top level joining write controller, storage array and read controller
`default_nettype none

module sync_fifo_top
   import sync_fifo_pkg::*;
(
   input  logic       pos_clk,
   input  logic       aresetn,
   // write side
   input  logic       wr_en_i,
   input  data_t      wr_data_i,
   // read side
   input  logic       rd_en_i,
   output data_t      rd_data_o,
   // status
   output wr_status_t wr_status_o,
   output rd_status_t rd_status_o
);

   // --------------------
   // internal nets
   // --------------------
   // registered pointers crossing between controllers
   ptr_t  wptr;
   ptr_t  rptr;
   // storage write port
   logic  mem_we;
   addr_t mem_waddr;
   // storage read port
   logic  mem_re;
   addr_t mem_raddr;

   // write controller, gated by full
   fifo_write_ctrl u_write_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en_i),
      .rptr_i      (rptr),
      .wptr_o      (wptr),
      .mem_we_o    (mem_we),
      .mem_waddr_o (mem_waddr),
      .wr_status_o (wr_status_o)
   );

   // storage array, payload is the data word
   fifo_ram #(
      .payload_t (data_t)
   ) u_ram (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .we_i    (mem_we),
      .waddr_i (mem_waddr),
      .wdata_i (wr_data_i),
      .re_i    (mem_re),
      .raddr_i (mem_raddr),
      .rdata_o (rd_data_o)
   );

   // read controller, gated by empty
   fifo_read_ctrl u_read_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .rd_en_i     (rd_en_i),
      .wptr_i      (wptr),
      .rptr_o      (rptr),
      .mem_re_o    (mem_re),
      .mem_raddr_o (mem_raddr),
      .rd_status_o (rd_status_o)
   );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// testbench clock source and power-on reset
`default_nettype none

module tb_clock_gen (
   output logic pos_clk_o,
   output logic aresetn_o
);

   // 20 unit period, toggles every 10
   initial begin
      pos_clk_o = 1'b0;
      forever begin
         #10 pos_clk_o = ~pos_clk_o;
      end
   end

   // low for two full periods, released on a falling edge
   initial begin
      aresetn_o = 1'b0;
      #40 aresetn_o = 1'b1;
   end

endmodule

`default_nettype wire

/* testbench/sync_fifo_sva.sv */
// concurrent FIFO status assertions and their bind to the top level
`default_nettype none

module sync_fifo_sva
   import sync_fifo_pkg::*;
(
   input wire logic       pos_clk_i,
   input wire logic       aresetn_i,
   input wire logic       wr_en_i,
   input wire wr_status_t wr_status_i,
   input wire rd_status_t rd_status_i
);

   // --------------------
   // flag consistency
   // --------------------
   // both ends of the level can't be hit at once
   assert property (@(posedge pos_clk_i) disable iff (!aresetn_i)
      !(wr_status_i.full && rd_status_i.empty))
      else $error("full and empty high together");

   // wack only after a write that full let through
   assert property (@(posedge pos_clk_i) disable iff (!aresetn_i)
      wr_status_i.wack |-> $past(wr_en_i && !wr_status_i.full))
      else $error("wack without an accepted write");

   // dvld only after a cycle with data available
   assert property (@(posedge pos_clk_i) disable iff (!aresetn_i)
      rd_status_i.dvld |-> $past(!rd_status_i.empty))
      else $error("dvld after an empty cycle");

   // --------------------
   // count range
   // --------------------
   assert property (@(posedge pos_clk_i) disable iff (!aresetn_i)
      (wr_status_i.wrcnt <= ptr_t'(FIFO_DEPTH)) && (rd_status_i.rdcnt <= ptr_t'(FIFO_DEPTH)))
      else $error("fill count above depth");

endmodule

bind sync_fifo_top sync_fifo_sva u_sva (
   .pos_clk_i   (pos_clk),
   .aresetn_i   (aresetn),
   .wr_en_i     (wr_en_i),
   .wr_status_i (wr_status_o),
   .rd_status_i (rd_status_o)
);

`default_nettype wire

/* testbench/tb_sync_fifo.sv */
// FIFO testbench with cycle model, compare tasks and test sequence
`default_nettype none

module tb_sync_fifo
   import sync_fifo_pkg::*;
();

   logic       pos_clk;
   logic       aresetn;
   logic       wr_en;
   data_t      wr_data;
   logic       rd_en;
   data_t      rd_data;
   wr_status_t wr_status;
   rd_status_t rd_status;

   integer seed;
   int     check_count;
   int     error_count;
   int     test_count;
   int     failed_tests;
   int     errors_at_start;

   // --------------------
   // cycle model state
   // --------------------
   // expected contents in write order
   data_t      m_q[$];
   ptr_t       m_wptr;
   ptr_t       m_rptr;
   wr_status_t m_wr;
   rd_status_t m_rd;
   // word expected with dvld
   data_t      m_rd_data;

   tb_clock_gen u_clk (
      .pos_clk_o (pos_clk),
      .aresetn_o (aresetn)
   );

   sync_fifo_top uut (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_en_i     (wr_en),
      .wr_data_i   (wr_data),
      .rd_en_i     (rd_en),
      .rd_data_o   (rd_data),
      .wr_status_o (wr_status),
      .rd_status_o (rd_status)
   );

   // --------------------
   // random helpers
   // --------------------
   function automatic data_t rand_word();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   // high with a chance of weight out of 16
   function automatic logic rand_bit(input int weight);
      logic [31:0] r;
      r = $random(seed);
      return (r % 32'd16) < weight;
   endfunction

   // --------------------
   // model
   // --------------------
   task automatic model_reset();
      m_q.delete();
      m_wptr = '0;
      m_rptr = '0;
      m_wr = '0;
      m_rd = '0;
      m_rd.empty = 1'b1;
      m_rd.aempty = 1'b1;
      m_rd_data = '0;
   endtask

   // one rising edge with the given inputs
   task automatic model_step(input logic we, input logic re, input data_t d);
      logic w_ok;
      logic r_ok;
      int   wlev;
      int   rlev;
      logic afull_n;
      logic aempty_n;
      w_ok = we && !m_wr.full;
      r_ok = re && !m_rd.empty;
      // levels mod 32 with look-ahead on the own pointer only
      wlev = (int'(m_wptr) + int'(w_ok) - int'(m_rptr) + 32) % 32;
      rlev = (int'(m_wptr) - int'(m_rptr) - int'(r_ok) + 64) % 32;
      // afull set takes priority over clear
      afull_n = m_wr.afull;
      if (we && wlev >= AFULL_LEVEL) begin
         afull_n = 1'b1;
      end else if (wlev <= AFULL_LEVEL) begin
         afull_n = 1'b0;
      end
      // aempty clear takes priority over set
      aempty_n = m_rd.aempty;
      if (m_rd.aempty && rlev >= AEMPTY_LEVEL) begin
         aempty_n = 1'b0;
      end else if (re && rlev <= AEMPTY_LEVEL) begin
         aempty_n = 1'b1;
      end
      // pulses use the flags from before the edge
      m_wr.overflow = we && m_wr.full;
      m_rd.underflow = re && m_rd.empty;
      m_wr.wack = w_ok;
      m_rd.dvld = r_ok;
      m_wr.full = (wlev >= FIFO_DEPTH);
      m_wr.afull = afull_n;
      m_wr.wrcnt = ptr_t'(wlev);
      m_rd.empty = (rlev == 0);
      m_rd.aempty = aempty_n;
      m_rd.rdcnt = ptr_t'(rlev);
      if (r_ok) begin
         m_rd_data = m_q.pop_front();
         m_rptr = m_rptr + 5'd1;
      end
      if (w_ok) begin
         m_q.push_back(d);
         m_wptr = m_wptr + 5'd1;
      end
   endtask

   // --------------------
   // compare tasks
   // --------------------
   task automatic check_data(input string name, input data_t got, input data_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_wr_status(input string name, input wr_status_t got,
                                  input wr_status_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_rd_status(input string name, input rd_status_t got,
                                  input rd_status_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic note_error(input string what);
      error_count++;
      $display("ERROR: %s at %0t", what, $time);
   endtask

   // a wait that ran out counts as an error
   task automatic report_timeout(input string what);
      error_count++;
      $display("TIMEOUT: %s at %0t", what, $time);
   endtask

   // --------------------
   // cycle driver
   // --------------------
   // entered and left on a falling edge
   task automatic run_cycle(input logic we, input logic re, input data_t d);
      wr_en = we;
      rd_en = re;
      wr_data = d;
      model_step(we, re, d);
      @(posedge pos_clk);
      @(negedge pos_clk);
      check_wr_status("wr_status_o", wr_status, m_wr);
      check_rd_status("rd_status_o", rd_status, m_rd);
      if (m_rd.dvld) begin
         check_data("rd_data_o", rd_data, m_rd_data);
      end
   endtask

   task automatic start_test();
      errors_at_start = error_count;
   endtask

   task automatic end_test(input string name);
      test_count++;
      if (error_count == errors_at_start) begin
         $display("test %s: ok", name);
      end else begin
         failed_tests++;
         $display("test %s: %0d errors", name, error_count - errors_at_start);
      end
   endtask

   // --------------------
   // test sequence
   // --------------------
   // every test in order, stops at the first wait that runs out
   task automatic execute_tests();
      int   n;
      int   cnt;
      logic seen_afull;
      logic seen_aempty_low;

      // idle edges leave the reset state as it is
      n = 0;
      while (aresetn !== 1'b1) begin
         if (n >= 10) begin
            report_timeout("reset never released");
            return;
         end
         @(posedge pos_clk);
         n++;
      end
      @(negedge pos_clk);

      start_test();
      check_wr_status("wr_status_o", wr_status, m_wr);
      check_rd_status("rd_status_o", rd_status, m_rd);
      check_data("rd_data_o", rd_data, '0);
      end_test("reset_values");

      // fill until full and push past it
      start_test();
      n = 0;
      cnt = 0;
      while (!wr_status.full) begin
         if (n >= 40) begin
            report_timeout("full never rose while filling");
            return;
         end
         run_cycle(1'b1, 1'b0, rand_word());
         if (wr_status.wack) cnt++;
         n++;
      end
      if (cnt != FIFO_DEPTH) note_error("wack count differs from FIFO depth on fill");
      // dropped writes
      repeat (3) begin
         run_cycle(1'b1, 1'b0, rand_word());
         if (!wr_status.overflow) note_error("write into full FIFO raised no overflow");
      end
      end_test("fill_to_full");

      // drain in order and read once more
      start_test();
      n = 0;
      cnt = 0;
      while (!rd_status.empty) begin
         if (n >= 40) begin
            report_timeout("empty never rose while draining");
            return;
         end
         run_cycle(1'b0, 1'b1, '0);
         if (rd_status.dvld) cnt++;
         n++;
      end
      if (cnt != FIFO_DEPTH) note_error("dvld count differs from FIFO depth on drain");
      run_cycle(1'b0, 1'b1, '0);
      if (!rd_status.underflow) note_error("read from empty FIFO raised no underflow");
      if (rd_status.dvld) note_error("read from empty FIFO gave dvld");
      end_test("drain");

      // fill mostly writing and drain mostly reading
      start_test();
      seen_afull = 1'b0;
      seen_aempty_low = 1'b0;
      n = 0;
      while (!wr_status.full) begin
         if (n >= 200) begin
            report_timeout("full never rose in threshold fill");
            return;
         end
         run_cycle(1'b1, rand_bit(4), rand_word());
         if (wr_status.afull) seen_afull = 1'b1;
         if (!rd_status.aempty) seen_aempty_low = 1'b1;
         n++;
      end
      n = 0;
      while (!rd_status.empty) begin
         if (n >= 200) begin
            report_timeout("empty never rose in threshold drain");
            return;
         end
         run_cycle(rand_bit(4), 1'b1, rand_word());
         n++;
      end
      if (!seen_afull) note_error("afull never rose during fill");
      if (!seen_aempty_low) note_error("aempty never cleared during fill");
      end_test("thresholds");

      // write-heavy half followed by read-heavy half
      start_test();
      for (int i = 0; i < 2000; i++) begin
         if (i < 1000) begin
            run_cycle(rand_bit(10), rand_bit(6), rand_word());
         end else begin
            run_cycle(rand_bit(6), rand_bit(10), rand_word());
         end
      end
      end_test("random_traffic");
   endtask

   initial begin
      seed = 32'h8a87ffbe;
      wr_en = 1'b0;
      rd_en = 1'b0;
      wr_data = '0;
      check_count = 0;
      error_count = 0;
      test_count = 0;
      failed_tests = 0;
      model_reset();

      execute_tests();

      // inputs back to idle
      wr_en = 1'b0;
      rd_en = 1'b0;
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sync_fifo.f */
hw/sync_fifo_pkg.sv
hw/fifo_write_ctrl.sv
hw/fifo_ram.sv
hw/fifo_read_ctrl.sv
hw/sync_fifo_top.sv
testbench/tb_clock_gen.sv
testbench/sync_fifo_sva.sv
testbench/tb_sync_fifo.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sync_fifo regression with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   --top-module tb_sync_fifo \
   -f sync_fifo.f \
   -o sim_tb_sync_fifo

# a nonzero exit (assertion stop, crash) counts as failure
./obj_dir/sim_tb_sync_fifo > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log

if grep -q "Regression failed" sim.log; then
   exit 1
fi
exit 0
